//--- Makefile
# Verilator build and run for the Ethernet loopback buffer

VERILATOR ?= verilator
TOP       ?= tb_eth_loop
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f project.f

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cold_reset.sv
module cold_reset import eth_loop_pkg::*; (
	input  logic clk156,
	input  logic rst,     // external reset, sync active high
	output logic sys_rst  // internal reset for the whole datapath
);

	logic [COLD_CNT_W-1:0] cold_cnt; // cycles since rst went low

	// keep the path in reset a while after the external reset lets go
	// mirrors the power-up hold-off that waits for the core to settle
	always_ff @(posedge clk156) begin
		if (rst) begin
			cold_cnt <= '0;
			sys_rst  <= 1'b1;
		end else if (cold_cnt != COLD_CNT_W'(COLD_RESET_CYCLES)) begin
			cold_cnt <= cold_cnt + 1'b1; // still counting
			sys_rst  <= 1'b1;
		end else begin
			sys_rst <= 1'b0; // counter parks at the top value
		end
	end

endmodule

//--- eth_loop_pkg.sv
package eth_loop_pkg;

	// ******************************
	// beat geometry
	// ******************************

	localparam int DATA_W = 64;        // bits per beat
	localparam int KEEP_W = DATA_W / 8; // one keep bit per byte

	// ******************************
	// buffer sizing
	// ******************************

	// ring of beats, one slot always left empty so full and empty differ
	localparam int BUF_DEPTH = 512;
	localparam int PTR_W     = $clog2(BUF_DEPTH); // 9 bits of address

	// hold-off after the external reset drops
	// kept short for simulation, hardware would hold much longer
	localparam int COLD_RESET_CYCLES = 16;
	localparam int COLD_CNT_W        = $clog2(COLD_RESET_CYCLES + 1); // must reach the full count

	localparam int DROP_W = 16; // dropped frame counter, wraps

	typedef logic [PTR_W-1:0] ptr_t; // buffer address

	// stored / transmitted beat, 73 bits
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [KEEP_W-1:0] keep; // byte enables
		logic              last; // end of frame
	} buf_beat_t;

	// received beat, 74 bits
	// bad only counts on the last beat (fcs or phy error from the mac)
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [KEEP_W-1:0] keep;
		logic              last;
		logic              bad;
	} rx_beat_t;

	// ******************************
	// FSM states
	// ******************************

	typedef enum logic [1:0] {
		WR_IDLE,  // waiting for the first beat of a frame
		WR_FRAME, // storing beats of a frame
		WR_DROP   // out of room, swallow the rest of the frame
	} wr_state_t;

	typedef enum logic {
		RD_IDLE, // no frame being fetched
		RD_SEND  // fetching beats of the current frame
	} rd_state_t;

endpackage

//--- eth_loop_top.sv
module eth_loop_top import eth_loop_pkg::*; (
	input  logic              clk156,
	input  logic              rst,
	// rx stream from the mac
	input  logic              rx_valid,
	input  rx_beat_t          rx_beat,
	// tx stream back to the mac
	input  logic              tx_ready,
	output logic              tx_valid,
	output buf_beat_t         tx_beat,
	output logic [DROP_W-1:0] frame_drops
);

	logic      sys_rst;      // internal reset after hold-off

	// writer to store
	logic      wr_en;
	ptr_t      wr_addr;
	buf_beat_t wr_data;
	logic      commit_en;

	// reader to store and writer
	logic      rd_en;
	ptr_t      rd_addr;
	buf_beat_t rd_data;
	logic      frame_done;
	logic      frames_ready;
	ptr_t      rd_ptr;

	cold_reset u_cold_reset (
		.clk156  (clk156),
		.rst     (rst),
		.sys_rst (sys_rst)
	);

	rx_frame_writer u_rx_writer (
		.clk156      (clk156),
		.sys_rst     (sys_rst),
		.rx_valid    (rx_valid),
		.rx_beat     (rx_beat),
		.rd_ptr      (rd_ptr),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.commit_en   (commit_en),
		.frame_drops (frame_drops)
	);

	frame_store u_store (
		.clk156       (clk156),
		.sys_rst      (sys_rst),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.commit_en    (commit_en),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.frame_done   (frame_done),
		.rd_data      (rd_data),
		.frames_ready (frames_ready)
	);

	tx_frame_reader u_tx_reader (
		.clk156       (clk156),
		.sys_rst      (sys_rst),
		.frames_ready (frames_ready),
		.rd_data      (rd_data),
		.tx_ready     (tx_ready),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.rd_ptr       (rd_ptr),
		.frame_done   (frame_done),
		.tx_valid     (tx_valid),
		.tx_beat      (tx_beat)
	);

endmodule

//--- frame_store.sv
module frame_store import eth_loop_pkg::*; (
	input  logic      clk156,
	input  logic      sys_rst,
	// write side, from the writer
	input  logic      wr_en,
	input  ptr_t      wr_addr,
	input  buf_beat_t wr_data,
	input  logic      commit_en,    // +1 complete frame
	// read side, from the reader
	input  logic      rd_en,
	input  ptr_t      rd_addr,
	input  logic      frame_done,   // -1 complete frame
	output buf_beat_t rd_data,      // valid the cycle after rd_en
	output logic      frames_ready  // at least one committed frame waiting
);

	// ******************************
	// beat memory
	// ******************************

	buf_beat_t mem [BUF_DEPTH]; // simple dual port ram, 73 bits wide

	always_ff @(posedge clk156) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr]; // registered read port
	end

	// ******************************
	// committed frame count
	// ******************************

	// at most BUF_DEPTH-1 one-beat frames fit, so PTR_W bits is enough
	logic [PTR_W-1:0] frame_cnt;

	always_ff @(posedge clk156) begin
		if (sys_rst) begin
			frame_cnt <= '0;
		end else begin
			case ({commit_en, frame_done})
				2'b10:   frame_cnt <= frame_cnt + 1'b1; // writer finished one
				2'b01:   frame_cnt <= frame_cnt - 1'b1; // reader sent one
				default: frame_cnt <= frame_cnt;        // none, or both cancel
			endcase
		end
	end

	assign frames_ready = (frame_cnt != '0);

endmodule

//--- project.f
eth_loop_pkg.sv
cold_reset.sv
rx_frame_writer.sv
frame_store.sv
tx_frame_reader.sv
eth_loop_top.sv
tb_eth_loop.sv

//--- rx_frame_writer.sv
module rx_frame_writer import eth_loop_pkg::*; (
	input  logic              clk156,
	input  logic              sys_rst,
	input  logic              rx_valid,    // mac rx is never stalled
	input  rx_beat_t          rx_beat,
	input  ptr_t              rd_ptr,      // oldest unsent beat from the reader
	output logic              wr_en,       // memory write port
	output ptr_t              wr_addr,
	output buf_beat_t         wr_data,
	output logic              commit_en,   // one frame now complete in memory
	output logic [DROP_W-1:0] frame_drops  // bad or overflowed frames
);

	wr_state_t state;

	ptr_t commit_ptr; // start of the frame being written
	ptr_t spec_ptr;   // speculative next free slot
	ptr_t spec_next;

	logic room;     // one more beat still leaves a gap before rd_ptr
	logic store;    // this beat goes into memory
	logic good_end; // last beat of a frame that is kept
	logic drop_end; // last beat of a frame that is thrown away

	// ******************************
	// space and frame end decode
	// ******************************

	assign spec_next = spec_ptr + 1'b1; // wraps with the ring

	// writing at spec_ptr leaves spec_next free unless it hits rd_ptr
	assign room = (spec_next != rd_ptr);

	assign store = rx_valid && room && (state != WR_DROP);

	assign good_end = rx_valid && rx_beat.last && store && !rx_beat.bad;
	assign drop_end = rx_valid && rx_beat.last && !good_end; // bad, full or already dropping

	// ******************************
	// pointers, counters, FSM
	// ******************************

	always_ff @(posedge clk156) begin
		if (sys_rst) begin
			state       <= WR_IDLE;
			commit_ptr  <= '0;
			spec_ptr    <= '0;
			wr_en       <= 1'b0;
			commit_en   <= 1'b0;
			frame_drops <= '0;
		end else begin
			wr_en     <= store;    // write lands one cycle after the beat
			commit_en <= good_end; // lines up with the last beat's write

			if (good_end) begin
				commit_ptr <= spec_next; // frame becomes visible
				spec_ptr   <= spec_next;
			end else if (drop_end) begin
				spec_ptr <= commit_ptr; // rewind so the partial frame is forgotten
			end else if (store) begin
				spec_ptr <= spec_next;
			end

			if (drop_end)
				frame_drops <= frame_drops + 1'b1;

			case (state)
				WR_IDLE: begin
					// single beat frames stay in idle
					if (rx_valid && !rx_beat.last)
						state <= room ? WR_FRAME : WR_DROP;
				end
				WR_FRAME: begin
					if (rx_valid) begin
						if (rx_beat.last)
							state <= WR_IDLE;
						else if (!room)
							state <= WR_DROP; // buffer filled mid frame
					end
				end
				WR_DROP: begin
					if (rx_valid && rx_beat.last)
						state <= WR_IDLE; // drop counted above
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	// memory write payload lags the beat by one cycle
	always_ff @(posedge clk156) begin
		if (store) begin
			wr_addr      <= spec_ptr;
			wr_data.data <= rx_beat.data;
			wr_data.keep <= rx_beat.keep;
			wr_data.last <= rx_beat.last;
		end
	end

endmodule

//--- tb_eth_loop.sv
module tb_eth_loop import eth_loop_pkg::*; ();

	localparam int HOLD_END     = 5 + COLD_RESET_CYCLES; // last cycle of rst plus hold-off
	localparam int DRAIN_CYCLES = 400;                   // slack for flushing and checks

	logic              clk156;
	logic              rst;
	logic              rx_valid;
	rx_beat_t          rx_beat;
	logic              tx_ready;
	logic              tx_valid;
	buf_beat_t         tx_beat;
	logic [DROP_W-1:0] frame_drops;

	int seed;          // frames, lengths, data, keep
	int rdy_seed;      // tx_ready pattern
	int ready_mode;    // 0 high, 1 random, 2 low
	int cyc;           // rising edges so far
	int limit;         // timeout limit that grows with beats sent
	int beats_sent;
	int beats_checked;
	int mismatches;
	int other_errors;

	buf_beat_t         exp_q [$]; // beats still owed by the DUT in order
	buf_beat_t         exp_beat;
	buf_beat_t         held_beat; // tx_beat seen during a stall
	logic              stalled;
	logic [DROP_W-1:0] exp_drops;

	eth_loop_top UUT (
		.clk156      (clk156),
		.rst         (rst),
		.rx_valid    (rx_valid),
		.rx_beat     (rx_beat),
		.tx_ready    (tx_ready),
		.tx_valid    (tx_valid),
		.tx_beat     (tx_beat),
		.frame_drops (frame_drops)
	);

	initial begin
		clk156 = 1'b0;
		forever #50 clk156 = ~clk156;
	end

	// ******************************
	// stimulus helpers
	// ******************************

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	task automatic drive_idle();
		@(posedge clk156);
		#10;
		rx_valid = 1'b0;
		rx_beat  = '0;
	endtask

	// mode changes on the edge and tx_ready follows 10 later
	task automatic set_ready_mode(input int m);
		@(posedge clk156);
		ready_mode = m;
	endtask

	task automatic send_frame(input int len, input bit bad_end, input bit expect_out,
		input bit gaps);
		rx_beat_t  b;
		buf_beat_t e;
		int        i;
		for (i = 0; i < len; i++) begin
			if (gaps && rand_below(4) == 0)
				drive_idle(); // rx_valid low inside the frame
			b.data = {$random(seed), $random(seed)};
			b.keep = KEEP_W'($random(seed));
			b.last = (i == len - 1);
			b.bad  = b.last ? bad_end : 1'($random(seed)); // only the last beat counts
			@(posedge clk156);
			#10;
			rx_valid = 1'b1;
			rx_beat  = b;
			beats_sent++;
			limit = HOLD_END + DRAIN_CYCLES + 4 * beats_sent;
			if (expect_out) begin
				e.data = b.data;
				e.keep = b.keep;
				e.last = b.last;
				exp_q.push_back(e);
			end
		end
		drive_idle(); // drop count of this frame is settled after this
	endtask

	// everything owed has left and tx is quiet
	task automatic wait_drain();
		while (exp_q.size() != 0 || tx_valid !== 1'b0) begin
			@(posedge clk156);
			#10;
		end
		repeat (8) @(posedge clk156);
		#10;
	endtask

	task automatic check_drops();
		assert (frame_drops === exp_drops) else begin
			mismatches++;
			$display("mismatch frame_drops: expected %h, got %h", exp_drops, frame_drops);
		end
	endtask

	task automatic finish_run();
		$display("summary: %0d beats checked, %0d mismatches, %0d other errors",
			beats_checked, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	always @(posedge clk156) begin
		#10;
		case (ready_mode)
			0:       tx_ready = 1'b1;
			1:       tx_ready = 1'($random(rdy_seed));
			default: tx_ready = 1'b0; // hold everything in the buffer
		endcase
	end

	// ******************************
	// checks sampled mid cycle
	// ******************************

	always @(negedge clk156) begin
		if (cyc >= 3 && cyc <= HOLD_END) begin // regs reset from the 2nd edge
			assert (tx_valid === 1'b0) else begin
				mismatches++;
				$display("mismatch tx_valid: expected %h, got %h in hold-off", 1'b0, tx_valid);
			end
			assert (frame_drops === '0) else begin
				mismatches++;
				$display("mismatch frame_drops: expected %h, got %h in hold-off",
					DROP_W'(0), frame_drops);
			end
		end
		if (stalled) begin
			assert (tx_valid === 1'b1) else begin
				other_errors++;
				$display("tx_valid dropped while a beat was waiting for tx_ready");
			end
			assert (tx_beat === held_beat) else begin
				mismatches++;
				$display("mismatch tx_beat under back-pressure: expected %h, got %h",
					held_beat, tx_beat);
			end
		end
		// transfer happens at the next rising edge
		if (tx_valid === 1'b1 && tx_ready === 1'b1) begin
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("beat came out on tx while no frame was owed, data %h", tx_beat.data);
			end else begin
				exp_beat = exp_q.pop_front();
				beats_checked++;
				assert (tx_beat === exp_beat) else begin
					mismatches++;
					$display("mismatch tx_beat: expected %h, got %h", exp_beat, tx_beat);
				end
			end
		end
		stalled   = (tx_valid === 1'b1) && (tx_ready !== 1'b1);
		held_beat = tx_beat;
	end

	always @(posedge clk156) begin
		cyc++;
		if (cyc > limit) begin
			other_errors++;
			$display("timeout after %0d cycles, %0d beats never came out", limit, exp_q.size());
			finish_run();
		end
	end

	// ******************************
	// test sequence
	// ******************************

	initial begin
		int i;
		int len;
		int t5_beats;
		int occ;
		bit fit;
		seed          = 32'hff14;
		rdy_seed      = 32'hff14;
		ready_mode    = 0;
		cyc           = 0;
		beats_sent    = 0;
		beats_checked = 0;
		mismatches    = 0;
		other_errors  = 0;
		stalled       = 1'b0;
		exp_drops     = '0;
		limit         = HOLD_END + DRAIN_CYCLES;
		rst           = 1'b1;
		rx_valid      = 1'b0;
		rx_beat       = '0;
		tx_ready      = 1'b1;
		repeat (5) @(posedge clk156);
		#10;
		rst = 1'b0;

		// 1. good and bad frames inside the hold-off are both ignored
		send_frame(4, 1'b0, 1'b0, 1'b0);
		send_frame(2, 1'b1, 1'b0, 1'b0);
		repeat (COLD_RESET_CYCLES) @(posedge clk156); // well past sys_rst release

		// 2. good frames with tx always ready
		for (i = 0; i < 12; i++)
			send_frame(1 + rand_below(20), 1'b0, 1'b1, 1'b0);
		wait_drain();
		check_drops();

		// 3. bad frames between good ones
		for (i = 0; i < 6; i++) begin
			if (i == 1 || i == 4) begin
				exp_drops = exp_drops + 1'b1;
				send_frame(1 + rand_below(20), 1'b1, 1'b0, 1'b0);
				check_drops(); // exactly one more
			end else begin
				send_frame(1 + rand_below(20), 1'b0, 1'b1, 1'b0);
			end
		end
		wait_drain();
		check_drops();

		// 4. random back-pressure and rx gaps stay under 320 beats so nothing overflows
		set_ready_mode(1);
		for (i = 0; i < 16; i++)
			send_frame(1 + rand_below(20), 1'b0, 1'b1, 1'b1);
		set_ready_mode(0);
		wait_drain();
		check_drops();

		// 5. fill the buffer with tx stalled
		set_ready_mode(2);
		occ      = 0; // buffer is empty after the drain
		t5_beats = 0;
		while (t5_beats < BUF_DEPTH + 80) begin
			len = 8 + rand_below(32);
			fit = (occ + len <= BUF_DEPTH - 1); // one slot always stays free
			if (fit)
				occ += len;
			else
				exp_drops = exp_drops + 1'b1;
			send_frame(len, 1'b0, fit, 1'b0);
			t5_beats += len;
		end
		check_drops();
		set_ready_mode(0);
		wait_drain();
		check_drops();

		finish_run();
	end

endmodule

//--- tx_frame_reader.sv
module tx_frame_reader import eth_loop_pkg::*; (
	input  logic      clk156,
	input  logic      sys_rst,
	input  logic      frames_ready, // committed frames waiting in the store
	input  buf_beat_t rd_data,      // memory read data, one cycle after rd_en
	input  logic      tx_ready,     // back-pressure from the tx side
	output logic      rd_en,
	output ptr_t      rd_addr,      // next beat to fetch
	output ptr_t      rd_ptr,       // oldest beat not yet sent
	output logic      frame_done,   // last beat of a frame left
	output logic      tx_valid,
	output buf_beat_t tx_beat
);

	rd_state_t state;

	logic rd_pend; // a read was issued last cycle, rd_data holds it now

	// two entry skid buffer in front of tx
	buf_beat_t  sk_mem [2];
	logic       sk_wr;   // write slot
	logic       sk_rd;   // read slot, head of the queue
	logic [1:0] sk_cnt;  // entries held
	logic [2:0] sk_next; // entries held next cycle

	logic push;      // memory data enters the skid
	logic pop;       // beat transfers on tx
	logic fetch_end; // last beat of the frame just came back from memory
	logic start;     // begin fetching the next frame

	// ******************************
	// handshake and fetch control
	// ******************************

	assign push      = rd_pend;
	assign pop       = tx_valid && tx_ready;
	assign fetch_end = rd_pend && rd_data.last;

	assign sk_next = {1'b0, sk_cnt} + {2'b0, push} - {2'b0, pop};

	// fetch only if the skid can take the beat even with one still in flight
	// no fetch once the last beat shows up, so nothing past the frame is read
	assign rd_en = (state == RD_SEND) && (sk_next < 3'd2) && !fetch_end;

	// next frame only after the previous one drained, frames_ready then
	// counts frames that are really still waiting
	assign start = (state == RD_IDLE) && frames_ready && (sk_cnt == 2'd0) && !rd_pend;

	assign tx_valid   = (sk_cnt != 2'd0);
	assign tx_beat    = sk_mem[sk_rd]; // holds while stalled
	assign frame_done = pop && tx_beat.last;

	// ******************************
	// pointers, skid, FSM
	// ******************************

	always_ff @(posedge clk156) begin
		if (sys_rst) begin
			state   <= RD_IDLE;
			rd_pend <= 1'b0;
			rd_addr <= '0;
			rd_ptr  <= '0;
			sk_wr   <= 1'b0;
			sk_rd   <= 1'b0;
			sk_cnt  <= 2'd0;
		end else begin
			rd_pend <= rd_en;
			if (rd_en)
				rd_addr <= rd_addr + 1'b1;

			// slot frees up for the writer only once the beat is gone
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				sk_rd  <= ~sk_rd;
			end
			if (push)
				sk_wr <= ~sk_wr;
			sk_cnt <= sk_next[1:0]; // never above two

			case (state)
				RD_IDLE: if (start)     state <= RD_SEND;
				RD_SEND: if (fetch_end) state <= RD_IDLE; // tail still in skid
				default:                state <= RD_IDLE;
			endcase
		end
	end

	// skid payload
	always_ff @(posedge clk156) begin
		if (push)
			sk_mem[sk_wr] <= rd_data;
	end

endmodule
